//--- design/rule_search_defines.svh
// Rule search widths and table sizing shared by the package and the RTL
`ifndef RULE_SEARCH_DEFINES_SVH
`define RULE_SEARCH_DEFINES_SVH

//////////////////////////////////////////////////
// Field widths
//////////////////////////////////////////////////
`define RS_KEY_W        24   // Search key
`define RS_DATA_W       32   // Rule payload
`define RS_ADDR_W       8    // Table address
`define RS_CNT_W        16   // Rule count in the frame header

//////////////////////////////////////////////////
// Frame and table sizing
//////////////////////////////////////////////////
`define RS_RULE_BYTES   7    // 3 key bytes then 4 data bytes
`define RS_TABLE_DEPTH  256  // Entries in the table memory

`endif

//--- design/rule_search_pkg.sv
// Rule search types with the width typedefs, the table memory request and the FSM states
`include "rule_search_defines.svh"

package rule_search_pkg;

	typedef logic [`RS_KEY_W-1:0]             rule_key_t;
	typedef logic [`RS_DATA_W-1:0]            rule_data_t;
	typedef logic [`RS_KEY_W+`RS_DATA_W-1:0]  rule_word_t;  // Key in the upper bits
	typedef logic [`RS_ADDR_W-1:0]            tab_addr_t;
	typedef logic [`RS_CNT_W-1:0]             rule_cnt_t;

	// One access to the table port
	typedef struct packed {
		logic       req;
		logic       we;
		tab_addr_t  addr;
		rule_word_t wdata;
	} mem_req_t;

	typedef enum logic [1:0] {
		L_INIT,    // Fill every entry with all ones
		L_IDLE,
		L_HEADER,  // Second count byte
		L_RULES
	} load_state_t;

	typedef enum logic [1:0] {
		S_IDLE,
		S_PROBE,   // Request held until granted
		S_WAIT,    // Word comes back
		S_DONE
	} srch_state_t;

endpackage

//--- design/rule_table_ram.sv
// Single-port rule table memory with a synchronous read of one cycle latency
`timescale 1ns/1ps
`include "rule_search_defines.svh"

module rule_table_ram
	import rule_search_pkg::*;
(
	input  logic       clk_i,
	input  logic       en_i,     // Port access this cycle
	input  logic       we_i,     // Write when set, read otherwise
	input  tab_addr_t  addr_i,
	input  rule_word_t wdata_i,
	output rule_word_t rdata_o   // Entry read on the previous access
);

	rule_word_t mem [`RS_TABLE_DEPTH];

	always_ff @(posedge clk_i) begin
		if (en_i) begin
			if (we_i) begin
				mem[addr_i] <= wdata_i;
			end
			else begin
				rdata_o <= mem[addr_i];  // Old data holds on a write
			end
		end
	end

endmodule

//--- design/table_arbiter.sv
// Table port arbiter that lets loader writes win over search reads
`timescale 1ns/1ps

module table_arbiter
	import rule_search_pkg::*;
(
	input  logic       clk_i,
	input  logic       rstn,
	input  mem_req_t   wr_req_i,     // Single-cycle loader write strobe
	input  mem_req_t   rd_req_i,     // Search read held until granted
	input  rule_word_t rd_word_i,    // From the memory
	output logic       rd_gnt_o,     // Read reaches the memory this cycle
	output logic       rd_vld_o,     // rd_word_o holds the granted read
	output rule_word_t rd_word_o,
	output logic       mem_en_o,
	output logic       mem_we_o,
	output tab_addr_t  mem_addr_o,
	output rule_word_t mem_wdata_o
);

	mem_req_t win;
	logic     r_rd_vld;

	// Fixed priority so the write is never held off
	assign win      = wr_req_i.req ? wr_req_i : rd_req_i;
	assign rd_gnt_o = rd_req_i.req & ~wr_req_i.req;

	assign mem_en_o    = win.req;
	assign mem_we_o    = win.we;
	assign mem_addr_o  = win.addr;
	assign mem_wdata_o = win.wdata;

	//////////////////////////////////////////////////
	// Read return
	//////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn) begin
		if (!rstn) begin
			r_rd_vld <= 1'b0;
		end
		else begin
			r_rd_vld <= rd_gnt_o;  // Memory answers one cycle later
		end
	end

	assign rd_vld_o  = r_rd_vld;
	assign rd_word_o = rd_word_i;

endmodule

//--- design/rule_loader.sv
// Rule loader that clears the table after reset and then writes rules from the byte stream
`timescale 1ns/1ps
`include "rule_search_defines.svh"

module rule_loader
	import rule_search_pkg::*;
(
	input  logic       clk_i,
	input  logic       rstn,
	input  logic       data_vd_i,  // One frame byte per strobe
	input  logic [7:0] data_i,
	output mem_req_t   wr_req_o,
	output logic       ready_o,    // Table usable for searches
	output logic       busy_o      // Frame rules being written
);

	localparam logic [2:0] c_last_byte = 3'(`RS_RULE_BYTES - 1);
	localparam rule_cnt_t  c_last_init = rule_cnt_t'(`RS_TABLE_DEPTH - 1);

	load_state_t r_state;
	rule_cnt_t   r_count;     // Rules in the current frame
	rule_cnt_t   r_wr_cnt;    // Sweep address and later the rule index
	logic [2:0]  r_byte_cnt;
	logic        r_wr_pend;   // Completed rule is written this cycle
	logic        r_ready;
	logic        r_busy;
	rule_word_t  r_word;
	rule_cnt_t   hdr_count;
	logic        last_byte;

	assign hdr_count = {r_count[`RS_CNT_W-9:0], data_i};
	assign last_byte = data_vd_i && (r_byte_cnt == c_last_byte);

	//////////////////////////////////////////////////
	// Frame FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn) begin
		if (!rstn) begin
			r_state    <= L_INIT;
			r_count    <= '0;
			r_wr_cnt   <= '0;
			r_byte_cnt <= '0;
			r_wr_pend  <= 1'b0;
			r_ready    <= 1'b0;
			r_busy     <= 1'b0;
		end
		else begin
			r_wr_pend <= (r_state == L_RULES) && last_byte;
			case (r_state)
				L_INIT: begin
					r_wr_cnt <= r_wr_cnt + 1'b1;
					if (r_wr_cnt == c_last_init) begin
						r_state <= L_IDLE;
						r_ready <= 1'b1;
					end
				end
				L_IDLE: begin
					if (data_vd_i) begin
						r_count <= rule_cnt_t'(data_i);  // High count byte
						r_state <= L_HEADER;
					end
				end
				L_HEADER: begin
					if (data_vd_i) begin
						r_count    <= hdr_count;
						r_wr_cnt   <= '0;
						r_byte_cnt <= '0;
						if (hdr_count != '0) begin
							r_state <= L_RULES;
							r_busy  <= 1'b1;
							r_ready <= 1'b0;
						end
						else begin
							r_state <= L_IDLE;  // Empty frame
						end
					end
				end
				L_RULES: begin
					if (data_vd_i) begin
						r_byte_cnt <= last_byte ? '0 : r_byte_cnt + 1'b1;
					end
					if (r_wr_pend) begin
						r_wr_cnt <= r_wr_cnt + 1'b1;
						// Last write of the frame
						if (r_wr_cnt == r_count - 1'b1) begin
							r_state <= L_IDLE;
							r_busy  <= 1'b0;
							r_ready <= 1'b1;
						end
					end
				end
				default: r_state <= L_IDLE;
			endcase
		end
	end

	// Rule assembly MSB first
	always_ff @(posedge clk_i) begin
		if ((r_state == L_RULES) && data_vd_i) begin
			r_word <= {r_word[$bits(rule_word_t)-9:0], data_i};
		end
	end

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////
	always_comb begin
		wr_req_o.req   = (r_state == L_INIT) | r_wr_pend;
		wr_req_o.we    = 1'b1;
		wr_req_o.addr  = r_wr_cnt[`RS_ADDR_W-1:0];
		wr_req_o.wdata = (r_state == L_INIT) ? '1 : r_word;  // Sweep fills all ones
	end

	assign ready_o = r_ready;
	assign busy_o  = r_busy;

endmodule

//--- design/rule_search_engine.sv
// Binary search engine over the sorted rule table with one probe at a time
`timescale 1ns/1ps
`include "rule_search_defines.svh"

module rule_search_engine
	import rule_search_pkg::*;
(
	input  logic       clk_i,
	input  logic       rstn,
	input  logic       search_i,    // Start strobe ignored while busy
	input  rule_key_t  key_i,
	input  logic       rd_gnt_i,
	input  logic       rd_vld_i,
	input  rule_word_t rd_word_i,
	output mem_req_t   rd_req_o,
	output logic       hit_vd_o,    // End of search
	output logic       hit_o,
	output tab_addr_t  hit_addr_o,
	output rule_data_t hit_data_o
);

	localparam tab_addr_t c_start_addr = tab_addr_t'(`RS_TABLE_DEPTH / 2);
	localparam tab_addr_t c_start_step = tab_addr_t'(`RS_TABLE_DEPTH / 4);

	srch_state_t r_state;
	rule_key_t   r_key;
	tab_addr_t   r_addr;     // Current probe
	tab_addr_t   r_step;     // Next move that halves every probe
	logic        r_final;    // Lower neighbour probe in flight
	logic        r_hit_vd;
	logic        r_hit;
	tab_addr_t   r_hit_addr;
	rule_data_t  r_hit_data;
	rule_key_t   probe_key;
	rule_data_t  probe_data;
	logic        match;

	assign probe_key  = rd_word_i[`RS_DATA_W +: `RS_KEY_W];
	assign probe_data = rd_word_i[`RS_DATA_W-1:0];
	assign match      = (probe_key == r_key);

	//////////////////////////////////////////////////
	// Search FSM
	//////////////////////////////////////////////////
	always_ff @(posedge clk_i or negedge rstn) begin
		if (!rstn) begin
			r_state  <= S_IDLE;
			r_addr   <= '0;
			r_step   <= '0;
			r_final  <= 1'b0;
			r_hit_vd <= 1'b0;
			r_hit    <= 1'b0;
		end
		else begin
			r_hit_vd <= 1'b0;
			case (r_state)
				S_IDLE: begin
					if (search_i) begin
						r_addr  <= c_start_addr;
						r_step  <= c_start_step;
						r_final <= 1'b0;
						r_state <= S_PROBE;
					end
				end
				S_PROBE: begin
					if (rd_gnt_i) r_state <= S_WAIT;  // A loader write can delay this
				end
				S_WAIT: begin
					if (rd_vld_i) begin
						if (match) begin
							r_hit    <= 1'b1;
							r_hit_vd <= 1'b1;
							r_state  <= S_DONE;
						end
						else if (r_final) begin
							r_hit    <= 1'b0;
							r_hit_vd <= 1'b1;
							r_state  <= S_DONE;
						end
						else if (r_step == '0) begin
							// Target can only sit just below the last probe
							r_addr  <= r_addr - 1'b1;
							r_final <= 1'b1;
							r_state <= S_PROBE;
						end
						else begin
							r_addr  <= (probe_key > r_key) ? r_addr - r_step : r_addr + r_step;
							r_step  <= r_step >> 1;
							r_state <= S_PROBE;
						end
					end
				end
				S_DONE: r_state <= S_IDLE;
				default: r_state <= S_IDLE;
			endcase
		end
	end

	// Key and hit payload
	always_ff @(posedge clk_i) begin
		if ((r_state == S_IDLE) && search_i) begin
			r_key <= key_i;
		end
		if ((r_state == S_WAIT) && rd_vld_i && match) begin
			r_hit_addr <= r_addr;
			r_hit_data <= probe_data;
		end
	end

	//////////////////////////////////////////////////
	// Table read request
	//////////////////////////////////////////////////
	always_comb begin
		rd_req_o.req   = (r_state == S_PROBE);
		rd_req_o.we    = 1'b0;
		rd_req_o.addr  = r_addr;
		rd_req_o.wdata = '0;
	end

	assign hit_vd_o   = r_hit_vd;
	assign hit_o      = r_hit;
	assign hit_addr_o = r_hit_addr;
	assign hit_data_o = r_hit_data;

endmodule

//--- design/rule_search_top.sv
// Rule search top with the loader and search engine sharing one table through the arbiter
`timescale 1ns/1ps

module rule_search_top
	import rule_search_pkg::*;
(
	input  logic       clk_i,
	input  logic       rstn,
	input  logic       data_vd_i,
	input  logic [7:0] data_i,
	input  logic       search_i,
	input  rule_key_t  key_i,
	output logic       ready_o,
	output logic       busy_o,
	output logic       hit_vd_o,
	output logic       hit_o,
	output tab_addr_t  hit_addr_o,
	output rule_data_t hit_data_o
);

	mem_req_t   wr_req;
	mem_req_t   rd_req;
	logic       rd_gnt;
	logic       rd_vld;
	rule_word_t rd_word;      // Arbiter to search engine
	rule_word_t ram_rdata;
	logic       mem_en;
	logic       mem_we;
	tab_addr_t  mem_addr;
	rule_word_t mem_wdata;

	//////////////////////////////////////////////////
	// Table users
	//////////////////////////////////////////////////
	rule_loader loader_inst (
		.clk_i     (clk_i),
		.rstn      (rstn),
		.data_vd_i (data_vd_i),
		.data_i    (data_i),
		.wr_req_o  (wr_req),
		.ready_o   (ready_o),
		.busy_o    (busy_o));

	rule_search_engine engine_inst (
		.clk_i      (clk_i),
		.rstn       (rstn),
		.search_i   (search_i),
		.key_i      (key_i),
		.rd_gnt_i   (rd_gnt),
		.rd_vld_i   (rd_vld),
		.rd_word_i  (rd_word),
		.rd_req_o   (rd_req),
		.hit_vd_o   (hit_vd_o),
		.hit_o      (hit_o),
		.hit_addr_o (hit_addr_o),
		.hit_data_o (hit_data_o));

	//////////////////////////////////////////////////
	// Shared table
	//////////////////////////////////////////////////
	table_arbiter arb_inst (
		.clk_i       (clk_i),
		.rstn        (rstn),
		.wr_req_i    (wr_req),
		.rd_req_i    (rd_req),
		.rd_word_i   (ram_rdata),
		.rd_gnt_o    (rd_gnt),
		.rd_vld_o    (rd_vld),
		.rd_word_o   (rd_word),
		.mem_en_o    (mem_en),
		.mem_we_o    (mem_we),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata));

	rule_table_ram ram_inst (
		.clk_i   (clk_i),
		.en_i    (mem_en),
		.we_i    (mem_we),
		.addr_i  (mem_addr),
		.wdata_i (mem_wdata),
		.rdata_o (ram_rdata));

endmodule

//--- verif/tb_rule_search.sv
// Rule search testbench that replays the trace of loads and searches and checks each result
`timescale 1ns/1ps

module tb_rule_search
	import rule_search_pkg::*;
();

	logic       clk_i = 1'b0;
	logic       rstn;
	logic       data_vd_i;
	logic [7:0] data_i;
	logic       search_i;
	rule_key_t  key_i;
	logic       ready_o;
	logic       busy_o;
	logic       hit_vd_o;
	logic       hit_o;
	tab_addr_t  hit_addr_o;
	rule_data_t hit_data_o;
	int         cycle_cnt   = 0;
	int         cycle_limit = 300;  // Reset and init sweep with more added per trace line

	always #2 clk_i = ~clk_i;  // 4 ns period

	rule_search_top DUT (.*);

	// Watchdog
	always @(posedge clk_i) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Some tests failed");
		$fatal(1);
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////
	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_addr(input string name, input tab_addr_t got, input tab_addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input rule_data_t got, input rule_data_t exp);
		if (got !== exp) begin
			$display("MISMATCH at time %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	task automatic send_byte(input logic [7:0] value, input int max_gap);
		data_vd_i = 1'b1;
		data_i    = value;
		next_cycle();
		data_vd_i = 1'b0;
		repeat ($urandom % (max_gap + 1)) next_cycle();  // Idle gap
	endtask

	// Key bytes first and MSB first
	task automatic send_rule(input rule_word_t word, input int max_gap);
		for (int i = 6; i >= 0; i--) send_byte(word[i*8 +: 8], max_gap);
	endtask

	task automatic send_header(input rule_cnt_t count, input int max_gap);
		send_byte(count[15:8], max_gap);
		send_byte(count[7:0], max_gap);
		check_bit("busy_o", busy_o, count != '0);  // Only a frame with rules sets busy
	endtask

	task automatic wait_ready(input logic exp_busy);
		while (ready_o !== 1'b1) begin
			check_bit("busy_o", busy_o, exp_busy);
			check_bit("hit_vd_o", hit_vd_o, 1'b0);
			next_cycle();
		end
		check_bit("busy_o", busy_o, 1'b0);
	endtask

	task automatic run_search(input rule_key_t key, input logic exp_hit,
			input tab_addr_t exp_addr, input rule_data_t exp_data, input rule_key_t extra_key);
		search_i = 1'b1;
		key_i    = key;
		next_cycle();
		search_i = 1'b0;
		// Second start while the first search is still probing
		if (extra_key != '1) begin
			search_i = 1'b1;
			key_i    = extra_key;
			next_cycle();
			search_i = 1'b0;
		end
		while (hit_vd_o !== 1'b1) next_cycle();
		check_bit("hit_o", hit_o, exp_hit);
		if (exp_hit) begin
			check_addr("hit_addr_o", hit_addr_o, exp_addr);
			check_data("hit_data_o", hit_data_o, exp_data);
		end
		// Single strobe and no second result after an ignored start
		repeat ((extra_key != '1) ? 24 : 1) begin
			next_cycle();
			check_bit("hit_vd_o", hit_vd_o, 1'b0);
		end
	endtask

	//////////////////////////////////////////////////
	// Trace replay
	//////////////////////////////////////////////////
	initial begin
		int            fd;
		int            gap;
		logic [7:0]    cmd;
		logic [1023:0] line;
		rule_cnt_t     count;
		rule_word_t    word;
		rule_key_t     key;
		rule_key_t     extra_key;
		logic          flag;
		tab_addr_t     addr;
		rule_data_t    data;
		void'($urandom(28));
		rstn      = 1'b0;
		data_vd_i = 1'b0;
		data_i    = '0;
		search_i  = 1'b0;
		key_i     = '0;
		fd = $fopen("verif/rule_search_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file verif/rule_search_trace.txt");
			abort_run();
		end
		repeat (5) @(posedge clk_i);
		#1;
		rstn = 1'b1;
		check_bit("hit_o", hit_o, 1'b0);
		// Init sweep writes one entry per cycle
		repeat (256) begin
			check_bit("ready_o", ready_o, 1'b0);
			check_bit("busy_o", busy_o, 1'b0);
			check_bit("hit_vd_o", hit_vd_o, 1'b0);
			next_cycle();
		end
		check_bit("ready_o", ready_o, 1'b1);
		while ($fscanf(fd, " %c", cmd) == 1) begin
			cycle_limit += 60;
			case (cmd)
				"#": void'($fgets(line, fd));
				"W": begin
					void'($fscanf(fd, "%h", flag));
					wait_ready(flag);
				end
				"L", "R": begin
					void'($fscanf(fd, "%h %d", count, gap));
					cycle_limit += (2 + 7 * int'(count)) * (gap + 1);  // Covers the B lines too
					send_header(count, gap);
					if (cmd == "R") begin
						for (int i = 0; i < int'(count); i++) begin
							word = {rule_key_t'(3 * i + 1), rule_data_t'(32'hA000_0000 | i)};
							send_rule(word, gap);
						end
					end
				end
				"B": begin
					void'($fscanf(fd, "%h %d", word, gap));
					send_rule(word, gap);
				end
				"S": begin
					void'($fscanf(fd, "%h %h %h %h %h", key, flag, addr, data, extra_key));
					run_search(key, flag, addr, data, extra_key);
				end
				default: begin
					$display("Unknown command %c in the trace file", cmd);
					abort_run();
				end
			endcase
		end
		$fclose(fd);
		$display("All tests passed");
		$finish;
	end

endmodule

//--- verif/rule_search_trace.txt
# Columns (hex, gaps decimal): W busy | L count gap | R count gap | B rule_word gap | S key hit addr data key2
# Gap is the most idle cycles after each byte, R sends keys 3i+1 with data A0000000+i, key2 FFFFFF is none
W 0
S 123456 0 00 00000000 FFFFFF
# Five sorted rules
L 0005 3
B 100010DEADBEEF 3
B 2000200BADF00D 2
B 30003012345678 3
B 4000408BADCAFE 1
B 500050CAFEF00D 2
W 1
S 100010 1 00 DEADBEEF FFFFFF
S 200020 1 01 0BADF00D FFFFFF
S 300030 1 02 12345678 FFFFFF
S 400040 1 03 8BADCAFE FFFFFF
S 500050 1 04 CAFEF00D FFFFFF
S 000005 0 00 00000000 FFFFFF
S 250000 0 00 00000000 FFFFFF
S 400041 0 00 00000000 FFFFFF
S 600000 0 00 00000000 FFFFFF
S 300030 1 02 12345678 100010
# Empty frame leaves the table unchanged
L 0000 1
W 0
S 200020 1 01 0BADF00D FFFFFF
# Full frame of 255 rules
R 00FF 1
W 1
S 000001 1 00 A0000000 FFFFFF
S 00017E 1 7F A000007F FFFFFF
S 0002FB 1 FE A00000FE FFFFFF
S 00012E 0 00 00000000 FFFFFF
# Short frame over the start of the full one
L 0003 2
B 00000211111111 2
B 00000322222222 0
B 00000933333333 1
W 1
S 000003 1 01 22222222 FFFFFF
S 00000A 1 03 A0000003 FFFFFF
S 000259 1 C8 A00000C8 FFFFFF
S 000004 0 00 00000000 FFFFFF
S 000009 1 02 33333333 000002

//--- files.f
+incdir+design
design/rule_search_pkg.sv
design/rule_table_ram.sv
design/table_arbiter.sv
design/rule_loader.sv
design/rule_search_engine.sv
design/rule_search_top.sv
verif/tb_rule_search.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_rule_search -o sim_rule_search &&
./obj_dir/sim_rule_search | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation run: PASS" || { echo "Simulation run: FAIL"; exit 1; }
